// ==== logic/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    localparam int inst_w   = 32;
    localparam int opcode_w = 5;
    localparam int funct3_w = 3;

    // major opcode taken from instruction bits 6 to 2.
    typedef enum logic [opcode_w-1:0] {
        op_load      = 5'b00000,
        op_ari_itype = 5'b00100,
        op_auipc     = 5'b00101,
        op_store     = 5'b01000,
        op_ari_rtype = 5'b01100,
        op_lui       = 5'b01101,
        op_branch    = 5'b11000,
        op_jalr      = 5'b11001,
        op_jal       = 5'b11011
    } opcode_e;

    typedef enum logic [funct3_w-1:0] {
        fn_beq  = 3'b000,
        fn_bne  = 3'b001,
        fn_blt  = 3'b100,
        fn_bge  = 3'b101,
        fn_bltu = 3'b110,
        fn_bgeu = 3'b111
    } branch_fn_e;

    // fn_add and fn_sr cover SUB and SRA through instruction bit 30.
    typedef enum logic [funct3_w-1:0] {
        fn_add  = 3'b000,
        fn_sll  = 3'b001,
        fn_slt  = 3'b010,
        fn_sltu = 3'b011,
        fn_xor  = 3'b100,
        fn_sr   = 3'b101,
        fn_or   = 3'b110,
        fn_and  = 3'b111
    } alu_fn_e;

    // addi x0, x0, 0.
    localparam logic [inst_w-1:0] nop_inst = 32'h0000_0013;

endpackage

`default_nettype wire

// ==== logic/core_ctrl_pkg.sv ====
`default_nettype none

package core_ctrl_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // source of the register write data. 2'b11 is never produced.
    typedef enum logic [1:0] {
        wb_pc4 = 2'b00,
        wb_mem = 2'b01,
        wb_alu = 2'b10
    } wb_sel_e;

endpackage

`default_nettype wire

// ==== logic/stage_ifs.sv ====
`timescale 1ns/10ps
`default_nettype none

// ======================================================================
// decode to execute
// ======================================================================
interface dx_if import rv_isa_pkg::*, core_ctrl_pkg::*; ();
    logic [inst_w-1:0] inst;
    logic [xlen-1:0]   pc;
    logic [xlen-1:0]   rs1_data;
    logic [xlen-1:0]   rs2_data;
    logic [xlen-1:0]   imm;

    modport src (output inst, pc, rs1_data, rs2_data, imm);
    modport dst (input inst, pc, rs1_data, rs2_data, imm);
endinterface

// ======================================================================
// execute to writeback
// ======================================================================
interface xw_if import rv_isa_pkg::*, core_ctrl_pkg::*; ();
    logic [inst_w-1:0] inst;
    logic [xlen-1:0]   pc4;
    logic [xlen-1:0]   alu_res;
    logic [xlen-1:0]   mem_rdata;

    modport src (output inst, pc4, alu_res, mem_rdata);
    modport dst (input inst, pc4, alu_res, mem_rdata);
endinterface

// ======================================================================
// controller steering, with the compare results coming back
// ======================================================================
interface steer_if import core_ctrl_pkg::*; ();
    logic    pc_sel;
    logic    alu1_sel;
    logic    alu2_sel;
    logic    brun;
    logic    dmem_we;
    wb_sel_e wb_sel;
    logic    we;
    logic    breq;
    logic    brlt;

    modport ctrl (output pc_sel, alu1_sel, alu2_sel, brun, dmem_we, wb_sel, we,
                  input breq, brlt);
    modport exe (input pc_sel, alu1_sel, alu2_sel, brun, dmem_we,
                 output breq, brlt);
    modport wb (input wb_sel, we);
endinterface

`default_nettype wire

// ==== logic/pipe_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_ctrl import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic run,
    dx_if.dst    dx,
    xw_if.dst    xw,
    steer_if.ctrl steer
);

    logic       dec_valid_q;
    logic       dec_valid;
    logic       exe_valid;
    logic       wb_valid;
    logic       br_cond;
    logic       taken;
    opcode_e    x_op;
    opcode_e    w_op;
    branch_fn_e x_fn;

    // dx holds the instruction now in execute, xw the one in writeback.
    assign x_op = opcode_e'(dx.inst[6:2]);
    assign x_fn = branch_fn_e'(dx.inst[14:12]);
    assign w_op = opcode_e'(xw.inst[6:2]);

    always_comb begin
        case (x_fn)
            fn_beq:          br_cond = steer.breq;
            fn_bne:          br_cond = !steer.breq;
            fn_blt, fn_bltu: br_cond = steer.brlt;
            fn_bge, fn_bgeu: br_cond = !steer.brlt;
            default:         br_cond = 1'b0;
        endcase
    end

    assign taken = exe_valid &&
                   (x_op == op_jal || x_op == op_jalr || (x_op == op_branch && br_cond));

    assign steer.pc_sel   = taken;
    assign steer.alu1_sel = x_op inside {op_auipc, op_jal, op_branch};
    assign steer.alu2_sel = x_op != op_ari_rtype;
    assign steer.brun     = x_fn inside {fn_bltu, fn_bgeu};
    assign steer.dmem_we  = exe_valid && x_op == op_store;

    always_comb begin
        case (x_op)
            op_jal, op_jalr: steer.wb_sel = wb_pc4;
            op_load:         steer.wb_sel = wb_mem;
            default:         steer.wb_sel = wb_alu;
        endcase
    end

    assign steer.we = wb_valid && (w_op inside {op_lui, op_auipc, op_jal, op_jalr, op_load,
                                                op_ari_itype, op_ari_rtype});

    // decode holds a real instruction only while the program runs.
    assign dec_valid = dec_valid_q && run;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid_q <= 1'b0;
            exe_valid   <= 1'b0;
            wb_valid    <= 1'b0;
        end else begin
            dec_valid_q <= 1'b1;
            exe_valid   <= dec_valid && !taken;
            wb_valid    <= exe_valid;
        end
    end

    // the instruction that redirects goes on to writeback.
    a_redirect_moves_on: assert property (@(posedge clk) disable iff (rst)
        steer.pc_sel |=> wb_valid && (w_op inside {op_jal, op_jalr, op_branch}));

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_stage import rv_isa_pkg::*, core_ctrl_pkg::*; #(
    parameter int imem_words = 256
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          run,
    input  logic                          prog_req,
    output logic                          prog_ack,
    input  logic [$clog2(imem_words)-1:0] prog_addr,
    input  logic [inst_w-1:0]             prog_data,
    steer_if.exe                          steer,
    input  logic [xlen-1:0]               redirect_pc,
    input  logic                          rf_we,
    input  logic [reg_addr_w-1:0]         rf_waddr,
    input  logic [xlen-1:0]               rf_wdata,
    dx_if.src                             dx
);

    localparam int imem_aw = $clog2(imem_words);

    logic [xlen-1:0]   pc;
    logic [inst_w-1:0] inst;
    logic [xlen-1:0]   imm;
    logic [inst_w-1:0] imem [imem_words];
    logic [xlen-1:0]   rf [1:31];

    // a write that lands this cycle is seen by the read.
    function automatic logic [xlen-1:0] rf_read(input logic [reg_addr_w-1:0] addr);
        logic [xlen-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (rf_we && rf_waddr == addr) begin
            val = rf_wdata;
        end else begin
            val = rf[addr];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            prog_ack <= 1'b0;
        end else begin
            prog_ack <= prog_req;
            if (!run) begin
                pc <= '0;
            end else if (steer.pc_sel) begin
                pc <= redirect_pc;
            end else begin
                pc <= pc + 4;
            end
        end
    end

    // the word is written once, on the rising side of the handshake.
    always_ff @(posedge clk) begin
        if (prog_req && !prog_ack) begin
            imem[prog_addr] <= prog_data;
        end
        if (rf_we && rf_waddr != '0) begin
            rf[rf_waddr] <= rf_wdata;
        end
    end

    assign inst = imem[pc[imem_aw+1:2]];

    always_comb begin
        case (opcode_e'(inst[6:2]))
            op_jalr, op_load, op_ari_itype: imm = {{20{inst[31]}}, inst[31:20]};
            op_store:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            op_branch: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            op_lui, op_auipc: imm = {inst[31:12], 12'b0};
            op_jal:    imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default:   imm = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        dx.inst     <= inst;
        dx.pc       <= pc;
        dx.rs1_data <= rf_read(inst[19:15]);
        dx.rs2_data <= rf_read(inst[24:20]);
        dx.imm      <= imm;
    end

    a_load_idle: assert property (@(posedge clk) disable iff (rst) !(prog_req && run));

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute_stage import rv_isa_pkg::*, core_ctrl_pkg::*; #(
    parameter int dmem_words = 256
) (
    input  logic                  clk,
    input  logic                  rst,
    dx_if.dst                     dx,
    steer_if.exe                  steer,
    input  logic                  fwd_we,
    input  logic [reg_addr_w-1:0] fwd_rd,
    input  logic [xlen-1:0]       fwd_data,
    output logic [xlen-1:0]       redirect_pc,
    xw_if.src                     xw
);

    localparam int dmem_aw = $clog2(dmem_words);

    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [xlen-1:0]       rs1;
    logic [xlen-1:0]       rs2;
    logic [xlen-1:0]       op_a;
    logic [xlen-1:0]       op_b;
    logic [xlen-1:0]       sum;
    logic [xlen-1:0]       alu_res;
    logic                  alt;
    opcode_e               opcode;
    alu_fn_e               alu_fn;
    logic [dmem_aw-1:0]    dmem_addr;
    logic [xlen-1:0]       dmem [dmem_words];

    assign opcode   = opcode_e'(dx.inst[6:2]);
    assign rs1_addr = dx.inst[19:15];
    assign rs2_addr = dx.inst[24:20];

    // the instruction in writeback has not reached the register file yet.
    assign rs1 = (fwd_we && fwd_rd != '0 && fwd_rd == rs1_addr) ? fwd_data : dx.rs1_data;
    assign rs2 = (fwd_we && fwd_rd != '0 && fwd_rd == rs2_addr) ? fwd_data : dx.rs2_data;

    // LUI has no rs1, so its sum is just the U immediate.
    assign op_a = steer.alu1_sel ? dx.pc : ((opcode == op_lui) ? '0 : rs1);
    assign op_b = steer.alu2_sel ? dx.imm : rs2;
    assign sum  = op_a + op_b;

    always_comb begin
        alu_fn = fn_add;
        alt    = 1'b0;
        if (opcode == op_ari_rtype || opcode == op_ari_itype) begin
            alu_fn = alu_fn_e'(dx.inst[14:12]);
            alt    = dx.inst[30] && (opcode == op_ari_rtype || alu_fn == fn_sr);
        end
    end

    always_comb begin
        case (alu_fn)
            fn_add:  alu_res = alt ? op_a - op_b : sum;
            fn_sll:  alu_res = op_a << op_b[4:0];
            fn_slt:  alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            fn_sltu: alu_res = {{(xlen-1){1'b0}}, op_a < op_b};
            fn_xor:  alu_res = op_a ^ op_b;
            fn_sr:   alu_res = alt ? xlen'($signed(op_a) >>> op_b[4:0]) : op_a >> op_b[4:0];
            fn_or:   alu_res = op_a | op_b;
            fn_and:  alu_res = op_a & op_b;
            default: alu_res = sum;
        endcase
    end

    assign steer.breq = rs1 == rs2;
    assign steer.brlt = steer.brun ? (rs1 < rs2) : ($signed(rs1) < $signed(rs2));

    assign redirect_pc = (opcode == op_jalr) ? {sum[xlen-1:1], 1'b0} : sum;

    // ======================================================================
    // data memory, word addressed
    // ======================================================================
    assign dmem_addr = sum[dmem_aw+1:2];

    always_ff @(posedge clk) begin
        if (steer.dmem_we) begin
            dmem[dmem_addr] <= rs2;
        end
        xw.mem_rdata <= dmem[dmem_addr];
        xw.pc4       <= dx.pc + 4;
        xw.alu_res   <= alu_res;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            xw.inst <= nop_inst;
        end else begin
            xw.inst <= dx.inst;
        end
    end

endmodule

`default_nettype wire

// ==== logic/writeback_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module writeback_stage import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    xw_if.dst                     xw,
    steer_if.wb                   steer,
    output logic                  rf_we,
    output logic [reg_addr_w-1:0] rf_waddr,
    output logic [xlen-1:0]       rf_wdata,
    output logic                  retire_valid,
    output logic [reg_addr_w-1:0] retire_rd,
    output logic [xlen-1:0]       retire_data
);

    wb_sel_e wb_sel_q;

    // the select is decoded a stage early and follows its instruction here.
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_sel_q <= wb_alu;
        end else begin
            wb_sel_q <= steer.wb_sel;
        end
    end

    always_comb begin
        case (wb_sel_q)
            wb_pc4:  rf_wdata = xw.pc4;
            wb_mem:  rf_wdata = xw.mem_rdata;
            default: rf_wdata = xw.alu_res;
        endcase
    end

    assign rf_we    = steer.we;
    assign rf_waddr = xw.inst[11:7];

    // writes to x0 change nothing and are not reported.
    assign retire_valid = rf_we && rf_waddr != '0;
    assign retire_rd    = rf_waddr;
    assign retire_data  = rf_wdata;

    // only a load takes the memory data.
    a_sel_follows: assert property (@(posedge clk) disable iff (rst)
        rf_we |-> ((wb_sel_q == wb_mem) == (opcode_e'(xw.inst[6:2]) == op_load)));

endmodule

`default_nettype wire

// ==== logic/rv3_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv3_core import rv_isa_pkg::*, core_ctrl_pkg::*; #(
    parameter int imem_words = 256,
    parameter int dmem_words = 256
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          prog_req,
    output logic                          prog_ack,
    input  logic [$clog2(imem_words)-1:0] prog_addr,
    input  logic [inst_w-1:0]             prog_data,
    input  logic                          run,
    output logic                          retire_valid,
    output logic [reg_addr_w-1:0]         retire_rd,
    output logic [xlen-1:0]               retire_data
);

    logic [xlen-1:0]       redirect_pc;
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;

    dx_if    dx ();
    xw_if    xw ();
    steer_if steer ();

    decode_stage #(
        .imem_words(imem_words)
    ) i_decode (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .prog_req    (prog_req),
        .prog_ack    (prog_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .steer       (steer),
        .redirect_pc (redirect_pc),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .dx          (dx)
    );

    execute_stage #(
        .dmem_words(dmem_words)
    ) i_execute (
        .clk         (clk),
        .rst         (rst),
        .dx          (dx),
        .steer       (steer),
        .fwd_we      (rf_we),
        .fwd_rd      (rf_waddr),
        .fwd_data    (rf_wdata),
        .redirect_pc (redirect_pc),
        .xw          (xw)
    );

    writeback_stage i_writeback (
        .clk          (clk),
        .rst          (rst),
        .xw           (xw),
        .steer        (steer),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    pipe_ctrl i_pipe_ctrl (
        .clk   (clk),
        .rst   (rst),
        .run   (run),
        .dx    (dx),
        .xw    (xw),
        .steer (steer)
    );

endmodule

`default_nettype wire

// ==== dv/rv3_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv3_core_tb;

    localparam int n_prog  = 7;
    localparam int n_slots = 8;
    localparam int limit   = n_prog * n_slots * 20 + n_prog * 10 * 8 + 20;

    logic        clk;
    logic        rst;
    logic        prog_req;
    logic        prog_ack;
    logic [7:0]  prog_addr;
    logic [31:0] prog_data;
    logic        run;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    logic [31:0] prog_mem [n_prog][n_slots];
    logic [4:0]  exp_rd   [n_prog][n_slots];
    logic [31:0] exp_val  [n_prog][n_slots];
    int          exp_cnt  [n_prog];
    logic [31:0] lfsr;
    int          cycles;
    int          cur_prog;
    int          ret_idx;

    rv3_core i_rv3_core (
        .clk          (clk),
        .rst          (rst),
        .prog_req     (prog_req),
        .prog_ack     (prog_ack),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .run          (run),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #50 clk = ~clk;

    // ======================================================================
    // instruction encoders and random source
    // ======================================================================
    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // fibonacci lfsr with taps 32, 22, 2 and 1.
    function automatic logic [31:0] take_bits(input int n);
        logic        fb;
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic put(input int p, input int slot, input logic [31:0] w);
        prog_mem[p][slot] = w;
    endtask

    task automatic expect_ret(input int p, input logic [4:0] rd, input logic [31:0] val);
        exp_rd[p][exp_cnt[p]]  = rd;
        exp_val[p][exp_cnt[p]] = val;
        exp_cnt[p]++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            $display("Verification failed");
            $fatal(1, "retire check");
        end
    endtask

    task automatic build_table();
        logic [31:0] a, b, u;
        logic [31:0] x1, x2, x3, x10, x11, x12, x13, x14, x15;
        for (int p = 0; p < n_prog; p++) begin
            exp_cnt[p] = 0;
            for (int s = 0; s < n_slots; s++) begin
                prog_mem[p][s] = 32'h0000_0013;
            end
        end
        a = take_bits(12);
        b = take_bits(12);
        u = take_bits(20);
        x1 = {{20{a[11]}}, a[11:0]};
        x2 = {{20{b[11]}}, b[11:0]};
        x3 = u << 12;
        // ALU operations on random operands.
        put(0, 0, enc_i(a[11:0], 0, 3'b000, 1, 7'h13));
        put(0, 1, enc_i(b[11:0], 0, 3'b000, 2, 7'h13));
        put(0, 2, {u[19:0], 5'd3, 7'h37});
        put(0, 3, {u[19:0], 5'd4, 7'h17});
        put(0, 4, enc_r(7'h00, 2, 1, 3'b000, 5));
        put(0, 5, enc_r(7'h20, 3, 1, 3'b000, 6));
        put(0, 6, enc_r(7'h00, 3, 2, 3'b100, 7));
        put(0, 7, enc_r(7'h00, 2, 1, 3'b010, 8));
        expect_ret(0, 1, x1);
        expect_ret(0, 2, x2);
        expect_ret(0, 3, x3);
        expect_ret(0, 4, x3 + 12);
        expect_ret(0, 5, x1 + x2);
        expect_ret(0, 6, x1 - x3);
        expect_ret(0, 7, x2 ^ x3);
        expect_ret(0, 8, {31'b0, $signed(x1) < $signed(x2)});
        // dependent chain, registers x1 to x3 carry over.
        x10 = $signed(x3) >>> x1[4:0];
        x11 = x10 + 1;
        x12 = x11 + x11;
        x13 = x12 - x1;
        x14 = x13 ^ x12;
        x15 = x14 - 7;
        put(1, 0, enc_r(7'h00, 3, 1, 3'b011, 9));
        put(1, 1, enc_r(7'h20, 1, 3, 3'b101, 10));
        put(1, 2, enc_i(12'd1, 10, 3'b000, 11, 7'h13));
        put(1, 3, enc_r(7'h00, 11, 11, 3'b000, 12));
        put(1, 4, enc_r(7'h20, 1, 12, 3'b000, 13));
        put(1, 5, enc_r(7'h00, 12, 13, 3'b100, 14));
        put(1, 6, enc_i(-12'sd7, 14, 3'b000, 15, 7'h13));
        put(1, 7, enc_r(7'h00, 14, 15, 3'b000, 16));
        expect_ret(1, 9, {31'b0, x1 < x3});
        expect_ret(1, 10, x10);
        expect_ret(1, 11, x11);
        expect_ret(1, 12, x12);
        expect_ret(1, 13, x13);
        expect_ret(1, 14, x14);
        expect_ret(1, 15, x15);
        expect_ret(1, 16, x15 + x14);
        // branches with x1 = -1 and x2 = 1.
        put(2, 0, enc_i(12'hfff, 0, 3'b000, 1, 7'h13));
        put(2, 1, enc_i(12'd1, 0, 3'b000, 2, 7'h13));
        put(2, 2, enc_b(13'd8, 2, 1, 3'b000));
        put(2, 3, enc_i(12'd1, 0, 3'b000, 21, 7'h13));
        put(2, 4, enc_b(13'd8, 2, 1, 3'b001));
        put(2, 5, enc_i(12'd2, 0, 3'b000, 22, 7'h13));
        put(2, 6, enc_b(13'd8, 2, 1, 3'b100));
        put(2, 7, enc_i(12'd3, 0, 3'b000, 23, 7'h13));
        expect_ret(2, 1, 32'hffff_ffff);
        expect_ret(2, 2, 32'd1);
        expect_ret(2, 21, 32'd1);
        put(3, 0, enc_b(13'd8, 2, 1, 3'b101));
        put(3, 1, enc_i(12'd4, 0, 3'b000, 24, 7'h13));
        put(3, 2, enc_b(13'd8, 2, 1, 3'b110));
        put(3, 3, enc_i(12'd5, 0, 3'b000, 25, 7'h13));
        put(3, 4, enc_b(13'd8, 2, 1, 3'b111));
        put(3, 5, enc_i(12'd6, 0, 3'b000, 26, 7'h13));
        put(3, 6, enc_b(13'd8, 1, 2, 3'b101));
        put(3, 7, enc_i(12'd7, 0, 3'b000, 27, 7'h13));
        expect_ret(3, 24, 32'd4);
        expect_ret(3, 25, 32'd5);
        put(4, 0, enc_b(13'd8, 2, 2, 3'b000));
        put(4, 1, enc_i(12'd8, 0, 3'b000, 28, 7'h13));
        put(4, 2, enc_b(13'd8, 2, 2, 3'b001));
        put(4, 3, enc_b(13'd8, 1, 2, 3'b100));
        put(4, 4, enc_b(13'd8, 1, 2, 3'b111));
        put(4, 5, enc_b(13'd8, 1, 2, 3'b110));
        put(4, 6, enc_i(12'd9, 0, 3'b000, 29, 7'h13));
        put(4, 7, enc_i(12'd10, 0, 3'b000, 30, 7'h13));
        expect_ret(4, 30, 32'd10);
        // jumps. jal lands on word 3, jalr on word 7.
        put(5, 0, enc_j(21'd12, 5));
        put(5, 1, enc_i(12'd1, 0, 3'b000, 6, 7'h13));
        put(5, 2, enc_i(12'd2, 0, 3'b000, 7, 7'h13));
        put(5, 3, enc_i(12'd28, 0, 3'b000, 8, 7'h13));
        put(5, 4, enc_i(12'd0, 8, 3'b000, 9, 7'h67));
        put(5, 5, enc_i(12'd3, 0, 3'b000, 6, 7'h13));
        put(5, 6, enc_i(12'd4, 0, 3'b000, 7, 7'h13));
        put(5, 7, enc_i(12'h055, 0, 3'b000, 10, 7'h13));
        expect_ret(5, 5, 32'd4);
        expect_ret(5, 8, 32'd28);
        expect_ret(5, 9, 32'd20);
        expect_ret(5, 10, 32'h55);
        // store then load back.
        put(6, 0, {20'h12345, 5'd1, 7'h37});
        put(6, 1, enc_i(12'h678, 1, 3'b000, 1, 7'h13));
        put(6, 2, enc_i(12'd64, 0, 3'b000, 2, 7'h13));
        put(6, 3, enc_s(12'd8, 1, 2));
        put(6, 4, enc_i(12'd8, 2, 3'b010, 3, 7'h03));
        put(6, 5, enc_r(7'h00, 3, 3, 3'b000, 4));
        expect_ret(6, 1, 32'h1234_5000);
        expect_ret(6, 1, 32'h1234_5678);
        expect_ret(6, 2, 32'd64);
        expect_ret(6, 3, 32'h1234_5678);
        expect_ret(6, 4, 32'h2468_acf0);
    endtask

    // ======================================================================
    // program load handshake
    // ======================================================================
    task automatic load_word(input logic [7:0] addr, input logic [31:0] data);
        int n;
        @(posedge clk);
        prog_addr <= addr;
        prog_data <= data;
        prog_req  <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!prog_ack && n < 10);
        if (!prog_ack) begin
            $display("prog_ack did not rise within 10 cycles of prog_req");
            $display("Verification failed");
            $fatal(1, "load handshake");
        end
        prog_req <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (prog_ack && n < 10);
        if (prog_ack) begin
            $display("prog_ack did not fall within 10 cycles of prog_req dropping");
            $display("Verification failed");
            $fatal(1, "load handshake");
        end
    endtask

    always @(posedge clk) begin
        if (!rst && retire_valid) begin
            if (ret_idx >= exp_cnt[cur_prog]) begin
                $display("program %0d retired more instructions than expected", cur_prog);
                $display("Verification failed");
                $fatal(1, "extra retire");
            end else begin
                check_value("retire_rd", 32'(retire_rd), 32'(exp_rd[cur_prog][ret_idx]));
                check_value("retire_data", retire_data, exp_val[cur_prog][ret_idx]);
                ret_idx <= ret_idx + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles while waiting for retires", cycles);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        run        = 1'b0;
        prog_req   = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        lfsr       = 32'he5f4_517a;
        cycles     = 0;
        cur_prog   = 0;
        ret_idx    = 0;
        build_table();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int p = 0; p < n_prog; p++) begin
            cur_prog = p;
            ret_idx  = 0;
            for (int s = 0; s < n_slots; s++) begin
                load_word(8'(s), prog_mem[p][s]);
            end
            // a jump to itself parks the core after the program.
            load_word(8'(n_slots), 32'h0000_006f);
            load_word(8'(n_slots + 1), 32'h0000_0013);
            @(posedge clk);
            run <= 1'b1;
            while (ret_idx < exp_cnt[p]) begin
                @(posedge clk);
            end
            repeat (10) @(posedge clk);
            run <= 1'b0;
            @(posedge clk);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/rv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/stage_ifs.sv
logic/pipe_ctrl.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/rv3_core.sv
dv/rv3_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= rv3_core_tb
RTL_TOP   ?= rv3_core
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Verification passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
